// File: design/sdramPkg.sv
package sdramPkg;

	// Memory geometry, one rank of 4 banks x 4096 rows x 256 columns
	localparam int BankBits = 2;
	localparam int RowBits = 12;
	localparam int ColBits = 8;
	localparam int DataBits = 16;
	localparam int MaskBits = DataBits / 8;

	// Host word address is {bank, row, col}
	localparam int AddrBits = BankBits + RowBits + ColBits;

	// Timing in sys_clk cycles
	localparam int InitWaitCycles = 2000; // 200 us at 10 MHz
	localparam int InitRefreshes = 8;
	localparam int RefreshInterval = 150;
	localparam int CasLatency = 3;
	localparam int WriteRecoverCycles = 2;
	localparam int ReadRecoverCycles = CasLatency + 1; // Holds the FSM until read completes

	// Mode register, CAS latency 3 and burst length 1
	localparam logic [RowBits-1:0] ModeWord = 12'h030;
	localparam int AutoPrechargeBit = 10; // A10

	// Counter widths
	localparam int WaitCntBits = $clog2(InitWaitCycles);
	localparam int InitRefBits = $clog2(InitRefreshes + 1);
	localparam int RefCntBits = $clog2(RefreshInterval + 16);

	typedef logic [DataBits-1:0] dataWord_t;
	typedef logic [AddrBits-1:0] hostAddr_t;

	// Encoded as {csN, rasN, casN, weN}
	typedef enum logic [3:0] {
		CmdNop       = 4'b1111,
		CmdActive    = 4'b0011,
		CmdRead      = 4'b0101,
		CmdWrite     = 4'b0100,
		CmdPrecharge = 4'b0010,
		CmdRefresh   = 4'b0001,
		CmdModeSet   = 4'b0000
	} sdramCmd_e;

	typedef enum logic [4:0] {
		StInitWait,
		StPrechargeAll,
		StInitRefresh,
		StInitGap,
		StModeSet,
		StIdle,
		StActivate,
		StRcdGap,
		StReadCmd,
		StWriteCmd,
		StRecover,
		StRefresh,
		StRefreshGap
	} seqState_e;

endpackage

// File: design/sdramReqDecode.sv
module sdramReqDecode (
	input  logic                                 sys_clk,
	input  logic                                 rstn,
	input  sdramPkg::hostAddr_t                  address,
	input  logic [sdramPkg::MaskBits-1:0]        byteEnable,
	input  logic                                 writeReq,
	input  logic                                 readReq,
	input  sdramPkg::dataWord_t                  writeData,
	input  logic                                 accept,
	output logic                                 reqValid,
	output logic                                 reqIsWrite,
	output logic [sdramPkg::BankBits-1:0]        bank,
	output logic [sdramPkg::RowBits-1:0]         row,
	output logic [sdramPkg::ColBits-1:0]         col,
	output sdramPkg::dataWord_t                  wrData,
	output logic [sdramPkg::MaskBits-1:0]        dqMask,
	output logic                                 isWrite
);

	// Exactly one strobe makes a legal request
	assign reqValid = writeReq ^ readReq;
	assign reqIsWrite = writeReq;

	// Direction of the request in flight
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			isWrite <= 1'b0;
		end else if (accept) begin
			isWrite <= writeReq;
		end
	end

	// Address split and write payload, held until the next accept
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			bank <= address[sdramPkg::AddrBits-1 -: sdramPkg::BankBits];
			row <= address[sdramPkg::ColBits +: sdramPkg::RowBits];
			col <= address[sdramPkg::ColBits-1:0];
			wrData <= writeData;
			dqMask <= ~byteEnable; // DQM high masks the byte
		end
	end

endmodule

// File: design/sdramCmdSequencer.sv
module sdramCmdSequencer (
	input  logic                                 sys_clk,
	input  logic                                 rstn,
	input  logic                                 reqValid,
	input  logic                                 reqIsWrite,
	input  logic [sdramPkg::BankBits-1:0]        bank,
	input  logic [sdramPkg::RowBits-1:0]         row,
	input  logic [sdramPkg::ColBits-1:0]         col,
	input  sdramPkg::dataWord_t                  wrData,
	input  logic [sdramPkg::MaskBits-1:0]        dqMask,
	input  logic                                 isWrite,
	output logic                                 accept,
	output logic                                 readIssued,
	output logic                                 writeDone,
	output logic                                 csN,
	output logic                                 rasN,
	output logic                                 casN,
	output logic                                 weN,
	output logic [sdramPkg::BankBits-1:0]        ba,
	output logic [sdramPkg::RowBits-1:0]         sdAddr,
	output logic [sdramPkg::MaskBits-1:0]        dqm,
	output sdramPkg::dataWord_t                  dqOut,
	output logic                                 dqOe
);

	sdramPkg::seqState_e state;
	sdramPkg::seqState_e nextState;
	sdramPkg::sdramCmd_e cmdNext;

	logic [sdramPkg::WaitCntBits-1:0] waitCnt; // Cycles spent in the current state
	logic [sdramPkg::WaitCntBits-1:0] initGapLast;
	logic [sdramPkg::WaitCntBits-1:0] recoverLast;
	logic [sdramPkg::InitRefBits-1:0] initRefCnt;
	logic [sdramPkg::RefCntBits-1:0] refreshCnt;
	logic [sdramPkg::BankBits-1:0] baNext;
	logic [sdramPkg::RowBits-1:0] addrNext;
	logic refreshDue;
	logic holdOff;

	// Two cycles early so the refresh lands within the interval
	assign refreshDue = refreshCnt >= sdramPkg::RefCntBits'(sdramPkg::RefreshInterval - 2);

	// One gap after precharge-all, two after each init refresh
	assign initGapLast = (initRefCnt == '0) ? '0 : sdramPkg::WaitCntBits'(1);

	// No new request in the completion cycle, the host still holds the old one
	assign accept = (state == sdramPkg::StIdle) && !refreshDue && reqValid && !holdOff;

	assign writeDone = (state == sdramPkg::StRecover) && isWrite && (waitCnt == recoverLast);

	always_comb begin
		nextState = state;
		case (state)
			sdramPkg::StInitWait:
				if (waitCnt == sdramPkg::WaitCntBits'(sdramPkg::InitWaitCycles - 1))
					nextState = sdramPkg::StPrechargeAll;
			sdramPkg::StPrechargeAll: nextState = sdramPkg::StInitGap;
			sdramPkg::StInitRefresh: nextState = sdramPkg::StInitGap;
			sdramPkg::StInitGap: begin
				if (waitCnt == initGapLast) begin
					if (initRefCnt == sdramPkg::InitRefBits'(sdramPkg::InitRefreshes))
						nextState = sdramPkg::StModeSet;
					else
						nextState = sdramPkg::StInitRefresh;
				end
			end
			sdramPkg::StModeSet: nextState = sdramPkg::StIdle;
			sdramPkg::StIdle: begin
				if (refreshDue)
					nextState = sdramPkg::StRefresh; // Refresh wins over the host
				else if (accept)
					nextState = sdramPkg::StActivate;
			end
			sdramPkg::StActivate: nextState = sdramPkg::StRcdGap;
			sdramPkg::StRcdGap:
				nextState = isWrite ? sdramPkg::StWriteCmd : sdramPkg::StReadCmd;
			sdramPkg::StReadCmd: nextState = sdramPkg::StRecover;
			sdramPkg::StWriteCmd: nextState = sdramPkg::StRecover;
			sdramPkg::StRecover:
				if (waitCnt == recoverLast)
					nextState = sdramPkg::StIdle;
			sdramPkg::StRefresh: nextState = sdramPkg::StRefreshGap;
			sdramPkg::StRefreshGap:
				if (waitCnt == sdramPkg::WaitCntBits'(1))
					nextState = sdramPkg::StIdle;
			default: nextState = sdramPkg::StIdle;
		endcase
	end

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state <= sdramPkg::StInitWait;
			waitCnt <= '0;
			initRefCnt <= '0;
			refreshCnt <= '0;
			recoverLast <= '0;
			holdOff <= 1'b0;
		end else begin
			state <= nextState;
			if (nextState != state)
				waitCnt <= '0;
			else
				waitCnt <= waitCnt + 1'b1;
			if (state == sdramPkg::StInitRefresh)
				initRefCnt <= initRefCnt + 1'b1;
			if (state == sdramPkg::StRefresh || state == sdramPkg::StInitRefresh)
				refreshCnt <= '0;
			else
				refreshCnt <= refreshCnt + 1'b1;
			// Recovery length follows the request direction
			if (accept)
				recoverLast <= reqIsWrite ?
					sdramPkg::WaitCntBits'(sdramPkg::WriteRecoverCycles - 1) :
					sdramPkg::WaitCntBits'(sdramPkg::ReadRecoverCycles - 1);
			holdOff <= (state == sdramPkg::StRecover) && (nextState == sdramPkg::StIdle);
		end
	end

	// Opcode and address mux per state
	always_comb begin
		cmdNext = sdramPkg::CmdNop;
		baNext = '0;
		addrNext = '0;
		case (state)
			sdramPkg::StPrechargeAll: begin
				cmdNext = sdramPkg::CmdPrecharge;
				addrNext[sdramPkg::AutoPrechargeBit] = 1'b1; // All banks
			end
			sdramPkg::StInitRefresh, sdramPkg::StRefresh: cmdNext = sdramPkg::CmdRefresh;
			sdramPkg::StModeSet: begin
				cmdNext = sdramPkg::CmdModeSet;
				addrNext = sdramPkg::ModeWord;
			end
			sdramPkg::StActivate: begin
				cmdNext = sdramPkg::CmdActive;
				baNext = bank;
				addrNext = row;
			end
			sdramPkg::StReadCmd, sdramPkg::StWriteCmd: begin
				cmdNext = (state == sdramPkg::StWriteCmd) ? sdramPkg::CmdWrite : sdramPkg::CmdRead;
				baNext = bank;
				addrNext[sdramPkg::ColBits-1:0] = col;
				addrNext[sdramPkg::AutoPrechargeBit] = 1'b1; // Auto-precharge
			end
			default: cmdNext = sdramPkg::CmdNop;
		endcase
	end

	// Command pins, one cycle behind the state
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			{csN, rasN, casN, weN} <= sdramPkg::CmdNop;
			ba <= '0;
			sdAddr <= '0;
			dqm <= '0;
			dqOe <= 1'b0;
			readIssued <= 1'b0;
		end else begin
			{csN, rasN, casN, weN} <= cmdNext;
			ba <= baNext;
			sdAddr <= addrNext;
			dqm <= (state == sdramPkg::StWriteCmd) ? dqMask : '0;
			dqOe <= (state == sdramPkg::StWriteCmd);
			readIssued <= (state == sdramPkg::StReadCmd); // Read now on the pins
		end
	end

	always_ff @(posedge sys_clk) begin
		dqOut <= wrData;
	end

endmodule

// File: design/sdramReadCapture.sv
module sdramReadCapture (
	input  logic                sys_clk,
	input  logic                rstn,
	input  logic                readIssued,
	input  logic                writeDone,
	input  sdramPkg::dataWord_t dqIn,
	output sdramPkg::dataWord_t readData,
	output logic                waitRequest
);

	// Stage n is high n+1 cycles after the read command reached the pins
	logic [sdramPkg::CasLatency:0] readPipe;
	logic writeAck;

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			readPipe <= '0;
			writeAck <= 1'b0;
		end else begin
			readPipe <= {readPipe[sdramPkg::CasLatency-1:0], readIssued};
			writeAck <= writeDone;
		end
	end

	// DQ valid at the edge where the read enters the last stage
	always_ff @(posedge sys_clk) begin
		if (readPipe[sdramPkg::CasLatency-1])
			readData <= dqIn;
	end

	// Single low cycle per completed transfer
	assign waitRequest = ~(writeAck | readPipe[sdramPkg::CasLatency]);

endmodule

// File: design/sdramCtrlTop.sv
module sdramCtrlTop (
	input  logic                                 sys_clk,
	input  logic                                 rstn,
	// Host port
	input  sdramPkg::hostAddr_t                  address,
	input  logic [sdramPkg::MaskBits-1:0]        byteEnable,
	input  logic                                 writeReq,
	input  logic                                 readReq,
	input  sdramPkg::dataWord_t                  writeData,
	output sdramPkg::dataWord_t                  readData,
	output logic                                 waitRequest,
	// SDRAM pins
	output logic                                 csN,
	output logic                                 rasN,
	output logic                                 casN,
	output logic                                 weN,
	output logic [sdramPkg::BankBits-1:0]        ba,
	output logic [sdramPkg::RowBits-1:0]         sdAddr,
	output logic [sdramPkg::MaskBits-1:0]        dqm,
	output sdramPkg::dataWord_t                  dqOut,
	output logic                                 dqOe,
	input  sdramPkg::dataWord_t                  dqIn
);

	logic reqValid;
	logic reqIsWrite;
	logic accept;
	logic isWrite;
	logic readIssued;
	logic writeDone;
	logic [sdramPkg::BankBits-1:0] bank;
	logic [sdramPkg::RowBits-1:0] row;
	logic [sdramPkg::ColBits-1:0] col;
	logic [sdramPkg::MaskBits-1:0] dqMask;
	sdramPkg::dataWord_t wrData;

	sdramReqDecode u_reqDecode (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.address   (address),
		.byteEnable(byteEnable),
		.writeReq  (writeReq),
		.readReq   (readReq),
		.writeData (writeData),
		.accept    (accept),
		.reqValid  (reqValid),
		.reqIsWrite(reqIsWrite),
		.bank      (bank),
		.row       (row),
		.col       (col),
		.wrData    (wrData),
		.dqMask    (dqMask),
		.isWrite   (isWrite)
	);

	sdramCmdSequencer u_cmdSequencer (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.reqValid  (reqValid),
		.reqIsWrite(reqIsWrite),
		.bank      (bank),
		.row       (row),
		.col       (col),
		.wrData    (wrData),
		.dqMask    (dqMask),
		.isWrite   (isWrite),
		.accept    (accept),
		.readIssued(readIssued),
		.writeDone (writeDone),
		.csN       (csN),
		.rasN      (rasN),
		.casN      (casN),
		.weN       (weN),
		.ba        (ba),
		.sdAddr    (sdAddr),
		.dqm       (dqm),
		.dqOut     (dqOut),
		.dqOe      (dqOe)
	);

	sdramReadCapture u_readCapture (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.readIssued (readIssued),
		.writeDone  (writeDone),
		.dqIn       (dqIn),
		.readData   (readData),
		.waitRequest(waitRequest)
	);

endmodule

// File: verification/sdramModel.sv
module sdramModel (
	input  logic                          sys_clk,
	input  logic                          rstn,
	input  logic                          csN,
	input  logic                          rasN,
	input  logic                          casN,
	input  logic                          weN,
	input  logic [sdramPkg::BankBits-1:0] ba,
	input  logic [sdramPkg::RowBits-1:0]  sdAddr,
	input  logic [sdramPkg::MaskBits-1:0] dqm,
	input  sdramPkg::dataWord_t           dqOut,
	input  logic                          dqOe,
	output sdramPkg::dataWord_t           dqIn,
	output logic                          protoFail
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int Banks = 1 << sdramPkg::BankBits;

	sdramPkg::sdramCmd_e cmd;
	sdramPkg::dataWord_t mem [int]; // Unwritten words read as zero
	sdramPkg::dataWord_t rdData [sdramPkg::CasLatency];
	logic [sdramPkg::CasLatency-1:0] rdValid;
	logic [sdramPkg::RowBits-1:0] openRow [Banks];
	logic [Banks-1:0] bankOpen;
	logic modeSet;
	string protoMsg;

	assign cmd = sdramPkg::sdramCmd_e'({csN, rasN, casN, weN});

	// Resolved DQ bus as seen by the controller
	assign dqIn = dqOe ? dqOut :
		(rdValid[sdramPkg::CasLatency-1] ? rdData[sdramPkg::CasLatency-1] : 'x);

	task automatic reportViolation(input string msg);
		protoMsg = msg;
		protoFail <= 1'b1;
	endtask

	always @(posedge sys_clk or negedge rstn) begin
		int key;
		sdramPkg::dataWord_t oldWord;
		if (!rstn) begin
			bankOpen <= '0;
			modeSet <= 1'b0;
			rdValid <= '0;
			protoFail <= 1'b0;
		end else begin
			key = {ba, openRow[ba], sdAddr[sdramPkg::ColBits-1:0]};
			oldWord = mem.exists(key) ? mem[key] : '0;
			rdValid <= {rdValid[sdramPkg::CasLatency-2:0], cmd == sdramPkg::CmdRead};
			for (int i = sdramPkg::CasLatency - 1; i > 0; i--)
				rdData[i] <= rdData[i-1];
			if (dqOe && (cmd != sdramPkg::CmdWrite || rdValid[sdramPkg::CasLatency-1]))
				reportViolation("DQ driven by the controller outside a write or over read data");
			case (cmd)
				sdramPkg::CmdNop: ;
				sdramPkg::CmdActive: begin
					if (!modeSet)
						reportViolation("activate before the mode register was set");
					else if (bankOpen[ba])
						reportViolation("activate on a bank that is already open");
					bankOpen[ba] <= 1'b1;
					openRow[ba] <= sdAddr;
				end
				sdramPkg::CmdRead, sdramPkg::CmdWrite: begin
					if (!bankOpen[ba])
						reportViolation("read or write on a closed bank");
					else if (!sdAddr[sdramPkg::AutoPrechargeBit])
						reportViolation("read or write without auto-precharge");
					bankOpen[ba] <= 1'b0; // Auto-precharge closes the row
					if (cmd == sdramPkg::CmdRead) begin
						rdData[0] <= oldWord;
					end else begin
						if (!dqOe)
							reportViolation("write command without DQ driven");
						mem[key] = {dqm[1] ? oldWord[15:8] : dqOut[15:8],
							dqm[0] ? oldWord[7:0] : dqOut[7:0]};
					end
				end
				sdramPkg::CmdPrecharge:
					if (sdAddr[sdramPkg::AutoPrechargeBit])
						bankOpen <= '0;
					else
						bankOpen[ba] <= 1'b0;
				sdramPkg::CmdRefresh:
					if (bankOpen != '0)
						reportViolation("refresh while a bank is open");
				sdramPkg::CmdModeSet: begin
					if (bankOpen != '0 || sdAddr != sdramPkg::ModeWord)
						reportViolation("mode set with an open bank or a wrong mode word");
					modeSet <= 1'b1;
				end
				default: reportViolation("unknown command on the pins");
			endcase
		end
	end

endmodule

// File: verification/tbSdramCtrl.sv
module tbSdramCtrl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WaitLimit = 2 * sdramPkg::InitWaitCycles;
	localparam int RefreshLimit = sdramPkg::RefreshInterval + 8; // One full read of slack
	localparam int PoolSize = 8;
	localparam int NumOps = 200;

	logic sys_clk;
	logic rstn;
	sdramPkg::hostAddr_t address;
	logic [sdramPkg::MaskBits-1:0] byteEnable;
	logic writeReq;
	logic readReq;
	sdramPkg::dataWord_t writeData;
	sdramPkg::dataWord_t readData;
	logic waitRequest;
	logic csN;
	logic rasN;
	logic casN;
	logic weN;
	logic [sdramPkg::BankBits-1:0] ba;
	logic [sdramPkg::RowBits-1:0] sdAddr;
	logic [sdramPkg::MaskBits-1:0] dqm;
	sdramPkg::dataWord_t dqOut;
	logic dqOe;
	sdramPkg::dataWord_t dqIn;
	logic protoFail;

	int unsigned lcgState;
	sdramPkg::hostAddr_t addrPool [PoolSize];
	sdramPkg::dataWord_t refMem [PoolSize];
	sdramPkg::hostAddr_t curAddr; // Request the host is holding
	sdramPkg::sdramCmd_e pinCmd;
	logic initDone;
	int sinceRefresh;

	assign pinCmd = sdramPkg::sdramCmd_e'({csN, rasN, casN, weN});

	sdramCtrlTop u_dut (
		.sys_clk(sys_clk), .rstn(rstn), .address(address), .byteEnable(byteEnable),
		.writeReq(writeReq), .readReq(readReq), .writeData(writeData),
		.readData(readData), .waitRequest(waitRequest),
		.csN(csN), .rasN(rasN), .casN(casN), .weN(weN), .ba(ba), .sdAddr(sdAddr),
		.dqm(dqm), .dqOut(dqOut), .dqOe(dqOe), .dqIn(dqIn)
	);

	sdramModel u_model (
		.sys_clk(sys_clk), .rstn(rstn), .csN(csN), .rasN(rasN), .casN(casN), .weN(weN),
		.ba(ba), .sdAddr(sdAddr), .dqm(dqm), .dqOut(dqOut), .dqOe(dqOe), .dqIn(dqIn),
		.protoFail(protoFail)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	function automatic int unsigned lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState >> 8; // Low bits have short periods
	endfunction

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkReadData(input sdramPkg::dataWord_t expected,
		input sdramPkg::dataWord_t actual);
		if (actual !== expected)
			stopWithFailure($sformatf("ERR readData expected %h actual %h", expected, actual));
	endtask

	task automatic checkCommand(input sdramPkg::sdramCmd_e expected,
		input sdramPkg::sdramCmd_e actual);
		if (actual !== expected)
			stopWithFailure($sformatf("ERR {csN,rasN,casN,weN} expected %h actual %h",
				expected, actual));
	endtask

	task automatic checkWait(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stopWithFailure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkAddr(input string name, input logic [sdramPkg::RowBits-1:0] expected,
		input logic [sdramPkg::RowBits-1:0] actual);
		if (actual !== expected)
			stopWithFailure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
	endtask

	// Next command other than NOP during init
	task automatic nextCommand(output sdramPkg::sdramCmd_e cmd);
		int cycles;
		cycles = 0;
		do begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > WaitLimit)
				stopWithFailure("Timed out waiting for the next init command");
		end while (pinCmd == sdramPkg::CmdNop);
		cmd = pinCmd;
	endtask

	// Runs from a falling edge to the falling edge of the completion cycle
	task automatic runTransfer(input int idx, input logic doWrite,
		input logic [sdramPkg::MaskBits-1:0] be, input sdramPkg::dataWord_t data);
		int cycles;
		sdramPkg::dataWord_t expected;
		curAddr = addrPool[idx];
		address = addrPool[idx];
		byteEnable = be;
		writeData = data;
		writeReq = doWrite;
		readReq = !doWrite;
		if (doWrite)
			refMem[idx] = {be[1] ? data[15:8] : refMem[idx][15:8],
				be[0] ? data[7:0] : refMem[idx][7:0]};
		expected = refMem[idx];
		@(negedge sys_clk);
		checkWait("waitRequest", 1'b1, waitRequest); // Previous low cycle was single
		cycles = 0;
		while (waitRequest) begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > WaitLimit)
				stopWithFailure("Timed out waiting for waitRequest to go low");
		end
		if (!doWrite)
			checkReadData(expected, readData);
		writeReq = 1'b0;
		readReq = 1'b0;
	endtask

	// Protocol, refresh spacing and address mapping
	always @(negedge sys_clk) begin
		logic [sdramPkg::RowBits-1:0] colAddr;
		colAddr = '0;
		colAddr[sdramPkg::ColBits-1:0] = curAddr[sdramPkg::ColBits-1:0];
		colAddr[10] = 1'b1;
		if (protoFail)
			stopWithFailure({"SDRAM model reports a protocol violation: ", u_model.protoMsg});
		if (rstn) begin
			sinceRefresh = (pinCmd == sdramPkg::CmdRefresh) ? 0 : sinceRefresh + 1;
			if (initDone && sinceRefresh >= RefreshLimit)
				stopWithFailure("No refresh was issued within the refresh interval");
			if (initDone && pinCmd != sdramPkg::CmdNop && pinCmd != sdramPkg::CmdRefresh) begin
				checkAddr("ba", sdramPkg::RowBits'(curAddr[sdramPkg::AddrBits-1 -: 2]),
					sdramPkg::RowBits'(ba));
				if (pinCmd == sdramPkg::CmdActive)
					checkAddr("sdAddr", curAddr[sdramPkg::ColBits +: sdramPkg::RowBits], sdAddr);
				else
					checkAddr("sdAddr", colAddr, sdAddr);
			end
		end
	end

	initial begin
		int unsigned r;
		sdramPkg::sdramCmd_e cmd;
		lcgState = 17863;
		rstn = 1'b0;
		address = '0;
		byteEnable = '0;
		writeReq = 1'b0;
		readReq = 1'b0;
		writeData = '0;
		curAddr = '0;
		initDone = 1'b0;
		sinceRefresh = 0;
		for (int i = 0; i < PoolSize; i++) begin
			r = lcgNext();
			// Distinct cols
			addrPool[i] = (sdramPkg::hostAddr_t'(r) & ~sdramPkg::hostAddr_t'(7)) |
				sdramPkg::hostAddr_t'(i);
			refMem[i] = '0;
		end
		repeat (5) begin
			@(negedge sys_clk);
			checkCommand(sdramPkg::CmdNop, pinCmd);
			checkWait("dqOe", 1'b0, dqOe);
			checkWait("waitRequest", 1'b1, waitRequest);
		end
		rstn = 1'b1;
		@(negedge sys_clk);
		checkCommand(sdramPkg::CmdNop, pinCmd);
		checkWait("dqOe", 1'b0, dqOe);
		checkWait("waitRequest", 1'b1, waitRequest);

		// Power-up sequence
		nextCommand(cmd);
		checkCommand(sdramPkg::CmdPrecharge, cmd);
		checkAddr("sdAddr[10]", sdramPkg::RowBits'(1), sdramPkg::RowBits'(sdAddr[10]));
		repeat (sdramPkg::InitRefreshes) begin
			nextCommand(cmd);
			checkCommand(sdramPkg::CmdRefresh, cmd);
		end
		nextCommand(cmd);
		checkCommand(sdramPkg::CmdModeSet, cmd);
		checkAddr("sdAddr", sdramPkg::ModeWord, sdAddr);
		initDone <= 1'b1;

		for (int n = 0; n < NumOps; n++) begin
			if (n == NumOps / 2) begin
				writeReq = 1'b1; // Illegal request with both strobes high
				readReq = 1'b1;
				repeat (20) begin
					@(negedge sys_clk);
					checkWait("waitRequest", 1'b1, waitRequest);
					if (pinCmd == sdramPkg::CmdActive)
						stopWithFailure("Activate issued for a request with both strobes high");
				end
				writeReq = 1'b0;
				readReq = 1'b0;
			end
			r = lcgNext();
			runTransfer(int'(r[22:20]), r[23], r[19:18], sdramPkg::dataWord_t'(lcgNext() >> 4));
			if (r[17]) begin
				@(negedge sys_clk);
				checkWait("waitRequest", 1'b1, waitRequest);
			end
		end

		if (protoFail)
			stopWithFailure({"SDRAM model reports a protocol violation: ", u_model.protoMsg});
		else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

// File: compile.f
design/sdramPkg.sv
design/sdramReqDecode.sv
design/sdramCmdSequencer.sv
design/sdramReadCapture.sv
design/sdramCtrlTop.sv
verification/sdramModel.sv
verification/tbSdramCtrl.sv

// File: runSim.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tbSdramCtrl -f compile.f -o simSdram \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simSdram > sim.log 2>&1 || true
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; } || true
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
